// ==== rtl/gomoku_pkg.sv ====
package gomoku_pkg;

    // Cell coding on the board.
    typedef logic [1:0] cell_t;

    localparam cell_t CELL_B   = 2'd0;  // Black stone.
    localparam cell_t CELL_W   = 2'd1;  // White stone.
    localparam cell_t CELL_E   = 2'd2;  // Empty.
    localparam cell_t CELL_BAD = 2'd3;  // Never legal.

    // Scan directions, each steps away from the anchor.
    typedef logic [1:0] dir_t;

    localparam dir_t DIR_VERT = 2'd0;  // Down.
    localparam dir_t DIR_HORZ = 2'd1;  // Right.
    localparam dir_t DIR_DR   = 2'd2;  // Down and right.
    localparam dir_t DIR_DL   = 2'd3;  // Down and left.

    typedef logic signed [31:0] score_t;

    localparam score_t FIVE         = 32'sd1000000;
    localparam score_t FOUR         = 32'sd100000;
    localparam score_t BLOCKED_FOUR = 32'sd10000;
    localparam score_t THREE        = 32'sd1000;
    localparam score_t TWO          = 32'sd100;

    // Cell 0 is the anchor and sits leftmost.
    typedef cell_t [0:4] win5_t;
    typedef cell_t [0:5] win6_t;

    localparam int N_FIVE = 12;
    localparam int N_SIX  = 14;

    localparam win5_t FIVE_PATTERNS [N_FIVE] = '{
        {CELL_B, CELL_B, CELL_B, CELL_B, CELL_B},
        {CELL_E, CELL_B, CELL_B, CELL_B, CELL_E},
        {CELL_E, CELL_B, CELL_E, CELL_B, CELL_E},
        {CELL_B, CELL_E, CELL_B, CELL_B, CELL_B},
        {CELL_B, CELL_B, CELL_B, CELL_E, CELL_B},
        {CELL_B, CELL_B, CELL_E, CELL_B, CELL_B},
        {CELL_W, CELL_W, CELL_W, CELL_W, CELL_W},
        {CELL_E, CELL_W, CELL_W, CELL_W, CELL_E},
        {CELL_E, CELL_W, CELL_E, CELL_W, CELL_E},
        {CELL_W, CELL_E, CELL_W, CELL_W, CELL_W},
        {CELL_W, CELL_W, CELL_W, CELL_E, CELL_W},
        {CELL_W, CELL_W, CELL_E, CELL_W, CELL_W}
    };

    localparam score_t FIVE_WEIGHTS [N_FIVE] = '{
        FIVE, THREE, TWO, BLOCKED_FOUR, BLOCKED_FOUR, BLOCKED_FOUR,
        FIVE, THREE, TWO, BLOCKED_FOUR, BLOCKED_FOUR, BLOCKED_FOUR
    };

    // Bit k set means entry k credits white.
    localparam logic [N_FIVE-1:0] FIVE_WHITE = 12'hfc0;

    localparam win6_t SIX_PATTERNS [N_SIX] = '{
        {CELL_E, CELL_B, CELL_B, CELL_B, CELL_B, CELL_E},  // Open four.
        {CELL_E, CELL_B, CELL_B, CELL_B, CELL_B, CELL_W},
        {CELL_W, CELL_B, CELL_B, CELL_B, CELL_B, CELL_E},
        {CELL_E, CELL_B, CELL_E, CELL_B, CELL_B, CELL_E},  // Jump threes.
        {CELL_E, CELL_B, CELL_B, CELL_E, CELL_B, CELL_E},
        {CELL_E, CELL_E, CELL_B, CELL_B, CELL_E, CELL_E},
        {CELL_E, CELL_B, CELL_E, CELL_E, CELL_B, CELL_E},
        {CELL_E, CELL_W, CELL_W, CELL_W, CELL_W, CELL_E},
        {CELL_E, CELL_W, CELL_W, CELL_W, CELL_W, CELL_B},
        {CELL_B, CELL_W, CELL_W, CELL_W, CELL_W, CELL_E},
        {CELL_E, CELL_W, CELL_E, CELL_W, CELL_W, CELL_E},
        {CELL_E, CELL_W, CELL_W, CELL_E, CELL_W, CELL_E},
        {CELL_E, CELL_E, CELL_W, CELL_W, CELL_E, CELL_E},
        {CELL_E, CELL_W, CELL_E, CELL_E, CELL_W, CELL_E}
    };

    localparam score_t SIX_WEIGHTS [N_SIX] = '{
        FOUR, BLOCKED_FOUR, BLOCKED_FOUR, THREE, THREE, TWO, TWO,
        FOUR, BLOCKED_FOUR, BLOCKED_FOUR, THREE, THREE, TWO, TWO
    };

    localparam logic [N_SIX-1:0] SIX_WHITE = 14'h3f80;

endpackage

// ==== rtl/scan_sequencer.sv ====
`timescale 1ns/10ps

module scan_sequencer #(
    parameter int BOARD_SIZE = 15
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start_i,
    output logic [3:0]       o_row_o,
    output logic [3:0]       o_col_o,
    output gomoku_pkg::dir_t o_dir_o,
    output logic             o_step_o,
    output logic             o_last_o
);

    typedef enum logic {
        S_IDLE,
        S_SCAN
    } state_t;

    localparam logic [3:0] LAST_IDX = 4'(BOARD_SIZE - 1);

    state_t state_r;
    logic   col_end;
    logic   row_end;
    logic   dir_end;

    assign col_end  = (o_col_o == LAST_IDX);
    assign row_end  = (o_row_o == LAST_IDX);
    assign dir_end  = (o_dir_o == gomoku_pkg::DIR_DL);
    assign o_step_o = (state_r == S_SCAN);  // One anchor per cycle while scanning.
    assign o_last_o = col_end && row_end && dir_end;  // Counters rest at zero while idle.

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            o_row_o <= '0;
            o_col_o <= '0;
            o_dir_o <= gomoku_pkg::DIR_VERT;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_start_i) begin
                        state_r <= S_SCAN;
                    end
                end
                S_SCAN: begin
                    if (o_last_o) begin
                        state_r <= S_IDLE;
                    end
                    o_col_o <= col_end ? 4'd0 : o_col_o + 4'd1;
                    if (col_end) begin
                        o_row_o <= row_end ? 4'd0 : o_row_o + 4'd1;
                        if (row_end) begin
                            o_dir_o <= o_dir_o + 2'd1;  // Wraps to vertical after the last.
                        end
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_last_o |-> o_step_o);

endmodule

// ==== rtl/window_fetch.sv ====
`timescale 1ns/10ps

module window_fetch #(
    parameter int BOARD_SIZE = 15
) (
    input  logic [BOARD_SIZE*BOARD_SIZE*2-1:0] i_board_i,
    input  logic [3:0]                         i_row_i,
    input  logic [3:0]                         i_col_i,
    input  gomoku_pkg::dir_t                   i_dir_i,
    input  logic                               i_step_i,
    input  logic                               i_last_i,
    output gomoku_pkg::win5_t                  o_win5_o,
    output gomoku_pkg::win6_t                  o_win6_o,
    output logic                               o_fit5_o,
    output logic                               o_fit6_o,
    output logic                               o_step_o,
    output logic                               o_last_o
);

    gomoku_pkg::cell_t cells [6];
    logic              on_board [6];

    always_comb begin
        int dr;
        int dc;
        int r;
        int c;
        dr = 1;
        dc = 0;
        case (i_dir_i)
            gomoku_pkg::DIR_VERT: dc = 0;
            gomoku_pkg::DIR_HORZ: begin
                dr = 0;
                dc = 1;
            end
            gomoku_pkg::DIR_DR: dc = 1;
            default: dc = -1;  // Down-left.
        endcase
        for (int k = 0; k < 6; k++) begin
            r = int'(i_row_i) + k * dr;
            c = int'(i_col_i) + k * dc;
            on_board[k] = (r < BOARD_SIZE) && (c >= 0) && (c < BOARD_SIZE);
            if (on_board[k]) begin
                cells[k] = i_board_i[(r * BOARD_SIZE + c) * 2 +: 2];
            end else begin
                cells[k] = gomoku_pkg::CELL_E;
            end
        end
    end

    assign o_win5_o = {cells[0], cells[1], cells[2], cells[3], cells[4]};
    assign o_win6_o = {cells[0], cells[1], cells[2], cells[3], cells[4], cells[5]};
    assign o_fit5_o = on_board[4];  // Path is monotonic, so the far cell decides.
    assign o_fit6_o = on_board[5];
    assign o_step_o = i_step_i;
    assign o_last_o = i_last_i;

endmodule

// ==== rtl/pattern_matcher.sv ====
`timescale 1ns/10ps

module pattern_matcher #(
    parameter type                window_t               = logic [9:0],
    parameter int                 N_PATTERNS             = 1,
    parameter window_t            PATTERNS [N_PATTERNS]  = '{default: '0},
    parameter gomoku_pkg::score_t WEIGHTS [N_PATTERNS]   = '{default: '0},
    parameter logic [N_PATTERNS-1:0] IS_WHITE            = '0
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  window_t            i_win_i,
    input  logic               i_fit_i,
    input  logic               i_step_i,
    input  logic               i_last_i,
    output gomoku_pkg::score_t o_black_o,
    output gomoku_pkg::score_t o_white_o,
    output logic               o_step_o,
    output logic               o_last_o
);

    localparam int N_CELLS = $bits(window_t) / 2;

    gomoku_pkg::score_t         black_sum;
    gomoku_pkg::score_t         white_sum;
    logic [$bits(window_t)-1:0] win_bits;
    logic                       illegal_cell;

    assign win_bits = i_win_i;

    // All entries compared in parallel.
    always_comb begin
        black_sum = '0;
        white_sum = '0;
        for (int k = 0; k < N_PATTERNS; k++) begin
            if (i_win_i == PATTERNS[k]) begin
                if (IS_WHITE[k]) begin
                    white_sum = white_sum + WEIGHTS[k];
                end else begin
                    black_sum = black_sum + WEIGHTS[k];
                end
            end
        end
    end

    always_comb begin
        illegal_cell = 1'b0;
        for (int k = 0; k < N_CELLS; k++) begin
            illegal_cell = illegal_cell || (win_bits[2*k +: 2] == gomoku_pkg::CELL_BAD);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_step_o <= 1'b0;
            o_last_o <= 1'b0;
        end else begin
            o_step_o <= i_step_i;
            o_last_o <= i_last_i;
        end
    end

    always_ff @(posedge i_clk) begin
        o_black_o <= (i_fit_i && i_step_i) ? black_sum : '0;  // Off-board windows score nothing.
        o_white_o <= (i_fit_i && i_step_i) ? white_sum : '0;
    end

    // The board held at the top level must carry legal codes for the whole scan.
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_step_i |-> !illegal_cell);

endmodule

// ==== rtl/score_accumulator.sv ====
`timescale 1ns/10ps

module score_accumulator (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_step_i,
    input  logic               i_last_i,
    input  gomoku_pkg::score_t i_black5_i,
    input  gomoku_pkg::score_t i_white5_i,
    input  gomoku_pkg::score_t i_black6_i,
    input  gomoku_pkg::score_t i_white6_i,
    output gomoku_pkg::score_t o_score_o,
    output logic               o_finish_o
);

    gomoku_pkg::score_t black_r;
    gomoku_pkg::score_t white_r;
    gomoku_pkg::score_t black_next;
    gomoku_pkg::score_t white_next;
    logic               first_r;  // Next step opens a new scan.

    assign black_next = (first_r ? '0 : black_r) + i_black5_i + i_black6_i;
    assign white_next = (first_r ? '0 : white_r) + i_white5_i + i_white6_i;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            first_r    <= 1'b1;
            o_finish_o <= 1'b0;
            o_score_o  <= '0;
        end else begin
            o_finish_o <= i_last_i;
            if (i_last_i) begin
                first_r   <= 1'b1;
                o_score_o <= black_next - white_next;  // Includes this step's sums.
            end else if (i_step_i) begin
                first_r <= 1'b0;
            end
        end
    end

    // Running totals.
    always_ff @(posedge i_clk) begin
        if (i_step_i) begin
            black_r <= black_next;
            white_r <= white_next;
        end
    end

endmodule

// ==== rtl/gomoku_score.sv ====
`timescale 1ns/10ps

module gomoku_score #(
    parameter int BOARD_SIZE = 15
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_start_i,
    input  logic [BOARD_SIZE*BOARD_SIZE*2-1:0] i_board_i,
    output gomoku_pkg::score_t                 o_score_o,
    output logic                               o_finish_o
);

    logic [3:0]         row;
    logic [3:0]         col;
    gomoku_pkg::dir_t   dir;
    logic               seq_step;
    logic               seq_last;
    gomoku_pkg::win5_t  win5;
    gomoku_pkg::win6_t  win6;
    logic               fit5;
    logic               fit6;
    logic               win_step;
    logic               win_last;
    gomoku_pkg::score_t black5;
    gomoku_pkg::score_t white5;
    gomoku_pkg::score_t black6;
    gomoku_pkg::score_t white6;
    logic               match_step;
    logic               match_last;

    scan_sequencer #(
        .BOARD_SIZE(BOARD_SIZE)
    ) u_seq (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_start_i(i_start_i),
        .o_row_o(row),
        .o_col_o(col),
        .o_dir_o(dir),
        .o_step_o(seq_step),
        .o_last_o(seq_last)
    );

    window_fetch #(
        .BOARD_SIZE(BOARD_SIZE)
    ) u_fetch (
        .i_board_i(i_board_i),
        .i_row_i(row),
        .i_col_i(col),
        .i_dir_i(dir),
        .i_step_i(seq_step),
        .i_last_i(seq_last),
        .o_win5_o(win5),
        .o_win6_o(win6),
        .o_fit5_o(fit5),
        .o_fit6_o(fit6),
        .o_step_o(win_step),
        .o_last_o(win_last)
    );

    pattern_matcher #(
        .window_t(gomoku_pkg::win5_t),
        .N_PATTERNS(gomoku_pkg::N_FIVE),
        .PATTERNS(gomoku_pkg::FIVE_PATTERNS),
        .WEIGHTS(gomoku_pkg::FIVE_WEIGHTS),
        .IS_WHITE(gomoku_pkg::FIVE_WHITE)
    ) u_match5 (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_win_i(win5),
        .i_fit_i(fit5),
        .i_step_i(win_step),
        .i_last_i(win_last),
        .o_black_o(black5),
        .o_white_o(white5),
        .o_step_o(),
        .o_last_o()
    );

    pattern_matcher #(
        .window_t(gomoku_pkg::win6_t),
        .N_PATTERNS(gomoku_pkg::N_SIX),
        .PATTERNS(gomoku_pkg::SIX_PATTERNS),
        .WEIGHTS(gomoku_pkg::SIX_WEIGHTS),
        .IS_WHITE(gomoku_pkg::SIX_WHITE)
    ) u_match6 (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_win_i(win6),
        .i_fit_i(fit6),
        .i_step_i(win_step),
        .i_last_i(win_last),
        .o_black_o(black6),
        .o_white_o(white6),
        .o_step_o(match_step),
        .o_last_o(match_last)
    );

    score_accumulator u_acc (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_step_i(match_step),
        .i_last_i(match_last),
        .i_black5_i(black5),
        .i_white5_i(white5),
        .i_black6_i(black6),
        .i_white6_i(white6),
        .o_score_o(o_score_o),
        .o_finish_o(o_finish_o)
    );

endmodule

// ==== include/score_model.svh ====
`ifndef SCORE_MODEL_SVH
`define SCORE_MODEL_SVH

localparam int MODEL_N = 15;

// Black minus white over every window that fits, direction by direction.
function automatic gomoku_pkg::score_t score_model(input logic [MODEL_N*MODEL_N*2-1:0] board);
    gomoku_pkg::score_t total;
    gomoku_pkg::win6_t  win;
    logic               on_board [6];
    int                 dr;
    int                 dc;
    int                 r;
    int                 c;
    total = '0;
    for (int d = 0; d < 4; d++) begin
        dr = (d == int'(gomoku_pkg::DIR_HORZ)) ? 0 : 1;
        dc = (d == int'(gomoku_pkg::DIR_VERT)) ? 0 : ((d == int'(gomoku_pkg::DIR_DL)) ? -1 : 1);
        for (int row = 0; row < MODEL_N; row++) begin
            for (int col = 0; col < MODEL_N; col++) begin
                for (int k = 0; k < 6; k++) begin
                    r = row + k * dr;
                    c = col + k * dc;
                    on_board[k] = (r < MODEL_N) && (c >= 0) && (c < MODEL_N);
                    win[k] = on_board[k] ? board[(r * MODEL_N + c) * 2 +: 2] : gomoku_pkg::CELL_E;
                end
                for (int p = 0; p < gomoku_pkg::N_FIVE; p++) begin
                    if (on_board[4] && win[0:4] == gomoku_pkg::FIVE_PATTERNS[p]) begin
                        if (gomoku_pkg::FIVE_WHITE[p]) total = total - gomoku_pkg::FIVE_WEIGHTS[p];
                        else total = total + gomoku_pkg::FIVE_WEIGHTS[p];
                    end
                end
                for (int p = 0; p < gomoku_pkg::N_SIX; p++) begin
                    if (on_board[5] && win == gomoku_pkg::SIX_PATTERNS[p]) begin
                        if (gomoku_pkg::SIX_WHITE[p]) total = total - gomoku_pkg::SIX_WEIGHTS[p];
                        else total = total + gomoku_pkg::SIX_WEIGHTS[p];
                    end
                end
            end
        end
    end
    return total;
endfunction

`endif

// ==== testbench/gomoku_score_tb.sv ====
`timescale 1ns/10ps

module gomoku_score_tb;

    localparam int          BOARD_SIZE  = 15;
    localparam int          BOARD_BITS  = BOARD_SIZE * BOARD_SIZE * 2;
    localparam int          SCAN_CYCLES = 4 * BOARD_SIZE * BOARD_SIZE + 2;
    localparam int          TIMEOUT     = 2000;
    localparam int          N_RANDOM    = 40;
    localparam logic [31:0] SEED        = 32'hc5e7_c7d6;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_start;
    logic [BOARD_BITS-1:0] i_board;
    gomoku_pkg::score_t    o_score;
    logic                  o_finish;
    logic [BOARD_BITS-1:0] board_buf;  // Board under construction.
    gomoku_pkg::score_t    black_score;

    `include "score_model.svh"

    gomoku_score #(
        .BOARD_SIZE(BOARD_SIZE)
    ) gomoku_score_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_start_i(i_start),
        .i_board_i(i_board),
        .o_score_o(o_score),
        .o_finish_o(o_finish)
    );

    always #10 i_clk = ~i_clk;

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_score(input gomoku_pkg::score_t expected, input gomoku_pkg::score_t actual);
        if (actual !== expected) begin
            $display("Error o_score_o expected %h actual %h", expected, actual);
            abort_run();
        end
    endtask

    task automatic check_delay(input int expected, input int actual);
        if (actual != expected) begin
            $display("Error o_finish_o delay expected %h actual %h", expected, actual);
            abort_run();
        end
    endtask

    function automatic void set_cell(input int r, input int c, input gomoku_pkg::cell_t v);
        board_buf[(r * BOARD_SIZE + c) * 2 +: 2] = v;
    endfunction

    function automatic void clear_board();
        board_buf = {(BOARD_SIZE * BOARD_SIZE){gomoku_pkg::CELL_E}};
    endfunction

    // About 15 percent black and 15 percent white.
    function automatic void fill_random();
        int pick;
        for (int i = 0; i < BOARD_SIZE * BOARD_SIZE; i++) begin
            pick = int'($urandom % 100);
            if (pick < 15) begin
                board_buf[i*2 +: 2] = gomoku_pkg::CELL_B;
            end else if (pick < 30) begin
                board_buf[i*2 +: 2] = gomoku_pkg::CELL_W;
            end else begin
                board_buf[i*2 +: 2] = gomoku_pkg::CELL_E;
            end
        end
    endfunction

    // Extra strobe at cycle extra_at lands while the scan is busy.
    task automatic run_scan(input int extra_at, output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        @(posedge i_clk);
        i_board <= board_buf;
        i_start <= 1'b1;
        while (!seen) begin
            @(posedge i_clk);
            cycles++;
            i_start <= (cycles == extra_at);
            @(negedge i_clk);
            seen = o_finish;
            if (!seen && cycles >= TIMEOUT) begin
                $display("No finish strobe within %0d cycles of the start strobe", TIMEOUT);
                abort_run();
            end
        end
    endtask

    task automatic evaluate_board(input int extra_at, input gomoku_pkg::score_t expected);
        int cycles;
        run_scan(extra_at, cycles);
        check_delay(SCAN_CYCLES, cycles);
        check_score(expected, o_score);
    endtask

    task automatic watch_quiet(input int n_cycles);
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge i_clk);
            if (o_finish) begin
                $display("Finish strobe seen with no scan in progress");
                abort_run();
            end
        end
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        clear_board();
        i_board = board_buf;
        void'($urandom(SEED));
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        watch_quiet(50);
        check_score('0, o_score);

        evaluate_board(0, '0);  // Empty board.

        clear_board();
        for (int c = 5; c < 10; c++) begin
            set_cell(7, c, gomoku_pkg::CELL_B);
        end
        black_score = score_model(board_buf);
        evaluate_board(0, black_score);
        for (int c = 5; c < 10; c++) begin
            set_cell(7, c, gomoku_pkg::CELL_W);
        end
        evaluate_board(0, -black_score);  // Colour swap negates.

        for (int n = 0; n < N_RANDOM; n++) begin
            fill_random();
            evaluate_board(0, score_model(board_buf));
        end

        // Second strobe mid-scan is dropped.
        evaluate_board(100, score_model(board_buf));
        watch_quiet(1000);

        clear_board();
        for (int k = 0; k < 5; k++) begin
            set_cell(0, 10 + k, gomoku_pkg::CELL_B);   // Right edge.
            set_cell(10 + k, 0, gomoku_pkg::CELL_W);   // Bottom edge.
            set_cell(10 + k, 3 + k, gomoku_pkg::CELL_W);
            set_cell(10 + k, 14 - k, gomoku_pkg::CELL_B);
        end
        evaluate_board(0, score_model(board_buf));

        $display("sim passed");
        $finish;
    end

endmodule

// ==== gomoku_score.f ====
+incdir+include
rtl/gomoku_pkg.sv
rtl/scan_sequencer.sv
rtl/window_fetch.sv
rtl/pattern_matcher.sv
rtl/score_accumulator.sv
rtl/gomoku_score.sv
testbench/gomoku_score_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the gomoku_score testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f gomoku_score.f \
        --top-module gomoku_score_tb -o Vgomoku_score_tb; then
    echo "verilator compile step returned an error"
    exit 1
fi

if ! ./obj_dir/Vgomoku_score_tb; then
    echo "simulation run returned an error"
    exit 1
fi

exit 0
